// File: include/fft_macros.svh
`ifndef FFT_MACROS_SVH
`define FFT_MACROS_SVH

// width of one real or imaginary part
`define FFT_PART_W 12

// points per frame
`define FFT_N 8

// stage count, also the width of a bin index
`define FFT_LOG_N 3

// fraction bits of the Q1.10 twiddles
`define FFT_TW_FRAC 10

// W8^1 = (cos(pi/4), -sin(pi/4)) in Q1.10
`define FFT_W1_RE 724
`define FFT_W1_IM (-724)

`endif

// File: design/fft_pkg.sv
`include "fft_macros.svh"

package fft_pkg;

    // one real or imaginary half
    typedef logic signed [`FFT_PART_W-1:0] part_t;

    // complex sample, real part in the upper half
    typedef logic [2*`FFT_PART_W-1:0] sample_t;

    // frequency bin index
    typedef logic [`FFT_LOG_N-1:0] bin_t;

    function automatic part_t re_of(sample_t s);
        return s[2*`FFT_PART_W-1:`FFT_PART_W];
    endfunction

    function automatic part_t im_of(sample_t s);
        return s[`FFT_PART_W-1:0];
    endfunction

    function automatic sample_t pack_sample(part_t re, part_t im);
        return {re, im};
    endfunction

endpackage

// File: design/fft_delay_line.sv
`timescale 1ns/1ps

module fft_delay_line #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     tick_i,
    input  payload_t d_i,
    output payload_t q_o
);

    payload_t sr_q [DEPTH];

    // shifts one place per tick, frozen otherwise
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < DEPTH; i++) begin
                sr_q[i] <= '0;
            end
        end else if (tick_i) begin
            sr_q[0] <= d_i;
            for (int i = 1; i < DEPTH; i++) begin
                sr_q[i] <= sr_q[i-1];
            end
        end
    end

    assign q_o = sr_q[DEPTH-1];

endmodule

// File: design/fft_twiddle_mult.sv
`timescale 1ns/1ps
`include "fft_macros.svh"

module fft_twiddle_mult #(
    parameter int STRIDE = 1
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             tick_i,
    input  logic [1:0]       idx_i,
    input  fft_pkg::sample_t d_i,
    output fft_pkg::sample_t q_o
);

    localparam int PROD_W = 2 * `FFT_PART_W;
    localparam logic signed [PROD_W-1:0] HALF_LSB = PROD_W'(1) << (`FFT_TW_FRAC - 1);
    localparam fft_pkg::part_t W1_RE = `FFT_W1_RE;
    localparam fft_pkg::part_t W3_RE = -`FFT_W1_RE;
    localparam fft_pkg::part_t WX_IM = `FFT_W1_IM;

    logic [1:0]               pow;
    fft_pkg::part_t           a_re;
    fft_pkg::part_t           a_im;
    fft_pkg::part_t           w_re;
    logic signed [PROD_W-1:0] acc_re;
    logic signed [PROD_W-1:0] acc_im;
    logic signed [PROD_W-1:0] rnd_re;
    logic signed [PROD_W-1:0] rnd_im;
    fft_pkg::sample_t         nxt;

    // exponent of W8, wraps mod 4 since only the lower half circle is used
    assign pow  = 2'(idx_i * STRIDE);
    assign a_re = fft_pkg::re_of(d_i);
    assign a_im = fft_pkg::im_of(d_i);

    // W1 and W3 share the imaginary part and differ in the sign of the real part
    assign w_re = pow[1] ? W3_RE : W1_RE;

    assign acc_re = a_re * w_re - a_im * WX_IM;
    assign acc_im = a_re * WX_IM + a_im * w_re;

    // round half up before dropping the fraction bits
    assign rnd_re = (acc_re + HALF_LSB) >>> `FFT_TW_FRAC;
    assign rnd_im = (acc_im + HALF_LSB) >>> `FFT_TW_FRAC;

    always_comb begin
        case (pow)
            2'd0:    nxt = d_i;
            // multiply by -j
            2'd2:    nxt = fft_pkg::pack_sample(a_im, -a_re);
            default: nxt = fft_pkg::pack_sample(rnd_re[`FFT_PART_W-1:0],
                                                rnd_im[`FFT_PART_W-1:0]);
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            q_o <= '0;
        end else if (tick_i) begin
            q_o <= nxt;
        end
    end

endmodule

// File: design/fft_sdf_stage.sv
`timescale 1ns/1ps
`include "fft_macros.svh"

module fft_sdf_stage #(
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             tick_i,
    input  fft_pkg::sample_t d_i,
    input  logic             valid_i,
    output fft_pkg::sample_t q_o,
    output logic             valid_o
);

    localparam int CNT_W = $clog2(2 * DEPTH);
    localparam int PW    = `FFT_PART_W;

    logic [CNT_W-1:0]  cnt_q;
    logic              started_q;
    logic              second_half;
    logic              valid_dly;
    logic signed [PW:0] sum_re;
    logic signed [PW:0] sum_im;
    logic signed [PW:0] dif_re;
    logic signed [PW:0] dif_im;
    fft_pkg::sample_t  sum_s;
    fft_pkg::sample_t  dif_s;
    fft_pkg::sample_t  fb_in;
    fft_pkg::sample_t  fb_out;

    // phase counter, held at zero until the first valid sample shows up
    always_ff @(posedge clk) begin
        if (!rstn) begin
            cnt_q     <= '0;
            started_q <= 1'b0;
        end else if (tick_i && (started_q || valid_i)) begin
            cnt_q     <= cnt_q + CNT_W'(1);
            started_q <= 1'b1;
        end
    end

    assign second_half = cnt_q[CNT_W-1];

    // butterfly, A is the new input and B the sample coming back from the delay
    assign sum_re = fft_pkg::re_of(d_i) + fft_pkg::re_of(fb_out);
    assign sum_im = fft_pkg::im_of(d_i) + fft_pkg::im_of(fb_out);
    assign dif_re = fft_pkg::re_of(fb_out) - fft_pkg::re_of(d_i);
    assign dif_im = fft_pkg::im_of(fb_out) - fft_pkg::im_of(d_i);

    // drop the lsb to halve both results
    assign sum_s = fft_pkg::pack_sample(sum_re[PW:1], sum_im[PW:1]);
    assign dif_s = fft_pkg::pack_sample(dif_re[PW:1], dif_im[PW:1]);

    assign q_o     = second_half ? sum_s : fb_out;
    assign fb_in   = second_half ? dif_s : d_i;
    assign valid_o = second_half ? valid_i : valid_dly;

    // the twiddle register stands in for the first slot of the feedback delay
    generate
        if (DEPTH > 1) begin : g_twiddle
            localparam int IDX_W = $clog2(DEPTH);

            logic [1:0]       tw_idx;
            fft_pkg::sample_t tw_q;

            // samples filling the delay pass through unrotated
            assign tw_idx = second_half ? 2'(cnt_q[IDX_W-1:0]) : 2'd0;

            fft_twiddle_mult #(
                .STRIDE(`FFT_N / (2 * DEPTH))
            ) u_twiddle (
                .clk   (clk),
                .rstn  (rstn),
                .tick_i(tick_i),
                .idx_i (tw_idx),
                .d_i   (fb_in),
                .q_o   (tw_q)
            );

            fft_delay_line #(
                .payload_t(fft_pkg::sample_t),
                .DEPTH    (DEPTH - 1)
            ) u_fb_delay (
                .clk   (clk),
                .rstn  (rstn),
                .tick_i(tick_i),
                .d_i   (tw_q),
                .q_o   (fb_out)
            );
        end else begin : g_plain
            fft_delay_line #(
                .payload_t(fft_pkg::sample_t),
                .DEPTH    (DEPTH)
            ) u_fb_delay (
                .clk   (clk),
                .rstn  (rstn),
                .tick_i(tick_i),
                .d_i   (fb_in),
                .q_o   (fb_out)
            );
        end
    endgenerate

    // differences leave DEPTH ticks after the samples they came from
    fft_delay_line #(
        .payload_t(logic),
        .DEPTH    (DEPTH)
    ) u_valid_delay (
        .clk   (clk),
        .rstn  (rstn),
        .tick_i(tick_i),
        .d_i   (valid_i),
        .q_o   (valid_dly)
    );

endmodule

// File: design/fft_ctrl.sv
`timescale 1ns/1ps
`include "fft_macros.svh"

module fft_ctrl (
    input  logic             clk,
    input  logic             rstn,

    input  logic             in_req_i,
    input  fft_pkg::sample_t in_data_i,
    input  logic             in_last_i,
    output logic             in_ack_o,

    output logic             out_req_o,
    output fft_pkg::sample_t out_data_o,
    output fft_pkg::bin_t    out_bin_o,
    input  logic             out_ack_i,

    output logic             tick_o,
    output fft_pkg::sample_t feed_data_o,
    output logic             feed_valid_o,
    input  fft_pkg::sample_t res_data_i,
    input  logic             res_valid_i
);

    localparam int OWED_W = `FFT_LOG_N + 2;

    logic [`FFT_LOG_N-1:0] slot_q;
    logic                  in_frame_q;
    logic [OWED_W-1:0]     owed_q;
    fft_pkg::bin_t         res_cnt_q;
    fft_pkg::bin_t         bin_rev;
    logic                  out_free;
    logic                  req_new;
    logic                  slot_zero;
    logic                  accept;
    logic                  flush;
    logic                  res_take;

    assign out_free  = !out_req_o && !out_ack_i;
    assign req_new   = in_req_i && !in_ack_o;
    assign slot_zero = (slot_q == '0);

    // a frame starts only at slot 0, later samples follow at any pace
    assign accept = out_free && req_new && (in_frame_q || slot_zero);

    // between frames, keep draining until nothing is owed and slot 0 is reached
    assign flush = !in_frame_q && (owed_q != '0 || !slot_zero) && !(req_new && slot_zero);

    assign tick_o   = accept || (out_free && flush);
    assign res_take = tick_o && res_valid_i;

    // results leave in bit-reversed bin order
    always_comb begin
        for (int i = 0; i < `FFT_LOG_N; i++) begin
            bin_rev[i] = res_cnt_q[`FFT_LOG_N-1-i];
        end
    end

    // slot counter, frame tracking and owed results
    always_ff @(posedge clk) begin
        if (!rstn) begin
            slot_q     <= '0;
            in_frame_q <= 1'b0;
            owed_q     <= '0;
        end else if (tick_o) begin
            slot_q <= slot_q + 1'b1;
            if (accept) begin
                in_frame_q <= !in_last_i;
            end
            owed_q <= owed_q
                      + ((accept && in_last_i) ? OWED_W'(`FFT_N) : OWED_W'(0))
                      - (res_valid_i ? OWED_W'(1) : OWED_W'(0));
        end
    end

    // input side of the four-phase handshake
    always_ff @(posedge clk) begin
        if (!rstn) begin
            in_ack_o <= 1'b0;
        end else if (accept) begin
            in_ack_o <= 1'b1;
        end else if (in_ack_o && !in_req_i) begin
            in_ack_o <= 1'b0;
        end
    end

    // feed register into stage 1, zeros with valid low on flush ticks
    always_ff @(posedge clk) begin
        if (!rstn) begin
            feed_data_o  <= '0;
            feed_valid_o <= 1'b0;
        end else if (tick_o) begin
            feed_data_o  <= accept ? in_data_i : '0;
            feed_valid_o <= accept;
        end
    end

    // output side of the four-phase handshake
    always_ff @(posedge clk) begin
        if (!rstn) begin
            out_req_o <= 1'b0;
            res_cnt_q <= '0;
        end else if (res_take) begin
            out_req_o <= 1'b1;
            res_cnt_q <= res_cnt_q + 1'b1;
        end else if (out_req_o && out_ack_i) begin
            out_req_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (res_take) begin
            out_data_o <= res_data_i;
            out_bin_o  <= bin_rev;
        end
    end

endmodule

// File: design/fft_top.sv
`timescale 1ns/1ps

module fft_top (
    input  logic             clk,
    input  logic             rstn,
    input  logic             in_req_i,
    input  fft_pkg::sample_t in_data_i,
    input  logic             in_last_i,
    output logic             in_ack_o,
    output logic             out_req_o,
    output fft_pkg::sample_t out_data_o,
    output fft_pkg::bin_t    out_bin_o,
    input  logic             out_ack_i
);

    logic             tick;
    fft_pkg::sample_t feed_data;
    logic             feed_valid;
    fft_pkg::sample_t s1_data;
    logic             s1_valid;
    fft_pkg::sample_t s2_in_data;
    logic             s2_in_valid;
    fft_pkg::sample_t s2_data;
    logic             s2_valid;
    fft_pkg::sample_t s3_in_data;
    logic             s3_in_valid;
    fft_pkg::sample_t res_data;
    logic             res_valid;

    fft_ctrl u_ctrl (
        .clk(clk), .rstn(rstn),
        .in_req_i(in_req_i), .in_data_i(in_data_i), .in_last_i(in_last_i),
        .in_ack_o(in_ack_o),
        .out_req_o(out_req_o), .out_data_o(out_data_o), .out_bin_o(out_bin_o),
        .out_ack_i(out_ack_i),
        .tick_o(tick), .feed_data_o(feed_data), .feed_valid_o(feed_valid),
        .res_data_i(res_data), .res_valid_i(res_valid)
    );

    fft_sdf_stage #(.DEPTH(4)) u_stage1 (
        .clk(clk), .rstn(rstn), .tick_i(tick),
        .d_i(feed_data), .valid_i(feed_valid), .q_o(s1_data), .valid_o(s1_valid)
    );

    // registers between stage 1 and stage 2
    fft_delay_line #(.payload_t(fft_pkg::sample_t), .DEPTH(1)) u_hop12_data (
        .clk(clk), .rstn(rstn), .tick_i(tick), .d_i(s1_data), .q_o(s2_in_data)
    );
    fft_delay_line #(.payload_t(logic), .DEPTH(1)) u_hop12_valid (
        .clk(clk), .rstn(rstn), .tick_i(tick), .d_i(s1_valid), .q_o(s2_in_valid)
    );

    fft_sdf_stage #(.DEPTH(2)) u_stage2 (
        .clk(clk), .rstn(rstn), .tick_i(tick),
        .d_i(s2_in_data), .valid_i(s2_in_valid), .q_o(s2_data), .valid_o(s2_valid)
    );

    // registers between stage 2 and stage 3
    fft_delay_line #(.payload_t(fft_pkg::sample_t), .DEPTH(1)) u_hop23_data (
        .clk(clk), .rstn(rstn), .tick_i(tick), .d_i(s2_data), .q_o(s3_in_data)
    );
    fft_delay_line #(.payload_t(logic), .DEPTH(1)) u_hop23_valid (
        .clk(clk), .rstn(rstn), .tick_i(tick), .d_i(s2_valid), .q_o(s3_in_valid)
    );

    fft_sdf_stage #(.DEPTH(1)) u_stage3 (
        .clk(clk), .rstn(rstn), .tick_i(tick),
        .d_i(s3_in_data), .valid_i(s3_in_valid), .q_o(res_data), .valid_o(res_valid)
    );

endmodule

// File: tb/fft_props.sv
`timescale 1ns/1ps

module fft_props (
    input logic             clk,
    input logic             rstn,
    input logic             in_req_i,
    input logic             in_ack_i,
    input logic             out_req_i,
    input fft_pkg::sample_t out_data_i,
    input fft_pkg::bin_t    out_bin_i,
    input logic             out_ack_i
);

    // number of failed properties, read by the testbench after the last test
    int unsigned viol_cnt = 0;

    // ack only answers a pending request
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rstn)
        $rose(in_ack_i) |-> $past(in_req_i))
    else begin
        viol_cnt++;
        $error("in_ack rose while in_req was low");
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!rstn)
        out_req_i && $past(out_req_i) |-> $stable(out_data_i) && $stable(out_bin_i))
    else begin
        viol_cnt++;
        $error("output data or bin changed while out_req was high");
    end

    // req is held until the ack has been seen
    a_req_held: assert property (@(posedge clk) disable iff (!rstn)
        out_req_i && !out_ack_i |=> out_req_i)
    else begin
        viol_cnt++;
        $error("out_req dropped before out_ack");
    end

    a_req_after_ack_low: assert property (@(posedge clk) disable iff (!rstn)
        $rose(out_req_i) |-> !$past(out_ack_i))
    else begin
        viol_cnt++;
        $error("out_req rose while out_ack was still high");
    end

    a_reset_idle: assert property (@(posedge clk)
        rstn && !$past(rstn) |-> !in_ack_i && !out_req_i)
    else begin
        viol_cnt++;
        $error("handshake outputs not idle after reset");
    end

endmodule

// File: tb/fft_tb.sv
`timescale 1ns/1ps
`include "fft_macros.svh"

module fft_tb;

    localparam int  PW         = `FFT_PART_W;
    localparam int  WAIT_LIMIT = 2000;
    localparam int  NFRAMES    = 6;
    localparam real PI         = 3.14159265358979;
    localparam real TOL        = 3.0;

    logic             clk;
    logic             rstn;
    logic             in_req_i;
    fft_pkg::sample_t in_data_i;
    logic             in_last_i;
    logic             in_ack_o;
    logic             out_req_o;
    fft_pkg::sample_t out_data_o;
    fft_pkg::bin_t    out_bin_o;
    logic             out_ack_i;

    logic [31:0]      lfsr_q;
    fft_pkg::sample_t frames [NFRAMES*`FFT_N];
    int               in_gap [3*`FFT_N];
    int               out_gap [3*`FFT_N];
    logic             hung;
    int               checks;
    int               errors;
    int               tests;

    fft_top u_fft_top (
        .clk(clk), .rstn(rstn),
        .in_req_i(in_req_i), .in_data_i(in_data_i), .in_last_i(in_last_i),
        .in_ack_o(in_ack_o),
        .out_req_o(out_req_o), .out_data_o(out_data_o), .out_bin_o(out_bin_o),
        .out_ack_i(out_ack_i)
    );

    bind fft_ctrl fft_props u_props (
        .clk(clk), .rstn(rstn),
        .in_req_i(in_req_i), .in_ack_i(in_ack_o),
        .out_req_i(out_req_o), .out_data_i(out_data_o), .out_bin_i(out_bin_o),
        .out_ack_i(out_ack_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = (v << 1) | int'(lfsr_q[0]);
        end
    endtask

    function automatic fft_pkg::sample_t make_sample(input int re, input int im);
        return {fft_pkg::part_t'(re), fft_pkg::part_t'(im)};
    endfunction

    function automatic int part_of(input fft_pkg::sample_t s, input bit want_im);
        if (want_im) begin
            return int'($signed(s[PW-1:0]));
        end
        return int'($signed(s[2*PW-1:PW]));
    endfunction

    function automatic int round_int(input real r);
        return (r < 0.0) ? $rtoi(r - 0.5) : $rtoi(r + 0.5);
    endfunction

    // reference DFT of one stored frame, scaled by 1/N like the pipeline
    function automatic real dft_part(input int f, input int k, input bit want_im);
        real acc;
        real th;
        real xr;
        real xi;
        acc = 0.0;
        for (int n = 0; n < `FFT_N; n++) begin
            th = 2.0 * PI * real'(k * n) / real'(`FFT_N);
            xr = real'(part_of(frames[f*`FFT_N+n], 1'b0));
            xi = real'(part_of(frames[f*`FFT_N+n], 1'b1));
            if (want_im) begin
                acc = acc + xi * $cos(th) - xr * $sin(th);
            end else begin
                acc = acc + xr * $cos(th) + xi * $sin(th);
            end
        end
        return acc / real'(`FFT_N);
    endfunction

    function automatic logic probe(input bit want_out);
        return want_out ? out_req_o : in_ack_o;
    endfunction

    // polls on falling edges until the level shows up or the limit runs out
    task automatic wait_level(input bit want_out, input logic level, input string what);
        int n;
        n = 0;
        while (probe(want_out) !== level && !hung) begin
            @(negedge clk);
            n++;
            if (n >= WAIT_LIMIT) begin
                $display("timeout waiting for %s to go %0b", what, level);
                hung = 1'b1;
            end
        end
    endtask

    task automatic send_frames(input int first, input int count);
        for (int i = 0; i < count * `FFT_N && !hung; i++) begin
            repeat (in_gap[i]) @(negedge clk);
            in_data_i = frames[first*`FFT_N+i];
            in_last_i = (i % `FFT_N == `FFT_N - 1);
            in_req_i  = 1'b1;
            wait_level(1'b0, 1'b1, "in_ack_o");
            in_req_i  = 1'b0;
            wait_level(1'b0, 1'b0, "in_ack_o");
        end
    endtask

    task automatic collect_results(input int first, input int count, output int errs);
        logic [`FFT_N-1:0] seen;
        int                f;
        int                act;
        real               exp_r;
        errs = 0;
        seen = '0;
        for (int r = 0; r < count * `FFT_N && !hung; r++) begin
            wait_level(1'b1, 1'b1, "out_req_o");
            f = first + r / `FFT_N;
            if (r % `FFT_N == 0) begin
                seen = '0;
            end
            assert (hung || !seen[out_bin_o]) else begin
                $display("FAILED out_bin_o: bin %h delivered twice in frame %0d", out_bin_o, f);
                errs++;
            end
            seen[out_bin_o] = 1'b1;
            for (int p = 0; p < 2 && !hung; p++) begin
                exp_r = dft_part(f, int'(out_bin_o), p == 1);
                act   = part_of(out_data_o, p == 1);
                checks++;
                assert (real'(act) - exp_r <= TOL && exp_r - real'(act) <= TOL) else begin
                    $display("FAILED out_data_o.%s bin %h: expected %h got %h",
                             (p == 1) ? "im" : "re", out_bin_o,
                             fft_pkg::part_t'(round_int(exp_r)), fft_pkg::part_t'(act));
                    errs++;
                end
            end
            repeat (out_gap[r]) @(negedge clk);
            out_ack_i = 1'b1;
            wait_level(1'b1, 1'b0, "out_req_o");
            out_ack_i = 1'b0;
        end
    endtask

    task automatic run_test(input string name, input int first, input int count,
                            input bit stall);
        int errs;
        int gap;
        if (!hung) begin
            for (int i = 0; i < 3 * `FFT_N; i++) begin
                in_gap[i]  = 0;
                out_gap[i] = 0;
                if (stall) begin
                    draw_bits(3, gap);
                    in_gap[i] = gap;
                    draw_bits(3, gap);
                    out_gap[i] = gap;
                end
            end
            fork
                send_frames(first, count);
                collect_results(first, count, errs);
            join
            tests++;
            errors += errs;
            $display("test %s: %0d frame(s), %0d errors%s", name, count, errs,
                     hung ? ", stopped by timeout" : "");
        end
    endtask

    initial begin
        int v_re;
        int v_im;
        rstn      = 1'b0;
        in_req_i  = 1'b0;
        in_data_i = '0;
        in_last_i = 1'b0;
        out_ack_i = 1'b0;
        lfsr_q    = 32'h9113;
        hung      = 1'b0;
        checks    = 0;
        errors    = 0;
        tests     = 0;

        // frame 0 impulse, 1 dc, 2 tone at bin 3, 3 to 5 random
        for (int n = 0; n < `FFT_N; n++) begin
            frames[n]          = make_sample((n == 0) ? 800 : 0, 0);
            frames[`FFT_N+n]   = make_sample(400, -200);
            frames[2*`FFT_N+n] = make_sample(round_int(480.0 * $cos(3.0 * PI * n / 4.0)),
                                             round_int(480.0 * $sin(3.0 * PI * n / 4.0)));
        end
        // 11-bit parts keep the 45 degree twiddle from overflowing
        for (int i = 3 * `FFT_N; i < NFRAMES * `FFT_N; i++) begin
            draw_bits(11, v_re);
            draw_bits(11, v_im);
            frames[i] = make_sample(v_re - 1024, v_im - 1024);
        end

        repeat (10) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);

        run_test("impulse", 0, 1, 1'b0);
        run_test("dc", 1, 1, 1'b0);
        run_test("tone", 2, 1, 1'b0);
        run_test("back-to-back", 3, 3, 1'b0);
        run_test("back-pressure", 3, 3, 1'b1);

        $display("tests %0d, checks %0d, errors %0d, property violations %0d",
                 tests, checks, errors, u_fft_top.u_ctrl.u_props.viol_cnt);
        if (errors == 0 && !hung && u_fft_top.u_ctrl.u_props.viol_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+include
design/fft_pkg.sv
design/fft_delay_line.sv
design/fft_twiddle_mult.sv
design/fft_sdf_stage.sv
design/fft_ctrl.sv
design/fft_top.sv
tb/fft_props.sv
tb/fft_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module fft_tb -f sim.f

status=0
out=$(./obj_dir/Vfft_tb +verilator+error+limit+100 2>&1) || status=$?
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
    echo "simulation passed"
else
    echo "simulation failed (exit status $status)"
    exit 1
fi
